/* logic/procPkg.sv */
// Shared types and sizes for the 16-bit pipelined processor, imported by every stage module
package procPkg;

   // Memory sizes, both word addressed
   localparam int imemDepth   = 256;
   localparam int dmemDepth   = 256;
   localparam int memAddrBits = 8;

   typedef logic [15:0] wordT;
   typedef logic [2:0]  regIdxT;

   // Major opcode in instr[15:11]
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opJ     = 5'b00100,
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,
      opXori  = 5'b01010,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opRtype = 5'b11011
   } opcodeT;

   // Same encoding as the RTYPE function field
   typedef enum logic [1:0] {aluAdd, aluSub, aluXor, aluAnd} aluOpT;

   typedef enum logic [1:0] {brNone, brEqz, brNez, brAlways} branchT;

   typedef struct packed {
      aluOpT  aluOp;
      logic   useImm;
      logic   regWrite;
      logic   memRead;
      logic   memWrite;
      branchT branch;
      logic   halt;
   } ctrlT;

   // Stage boundary payloads, all zero means bubble
   typedef struct packed {
      logic valid;
      wordT pc;
      wordT instr;
   } ifIdT;

   typedef struct packed {
      logic   valid;
      ctrlT   ctrl;
      wordT   pc;
      wordT   rsData;
      wordT   rtData;
      wordT   imm;
      regIdxT rd;
   } idExT;

   typedef struct packed {
      logic   valid;
      ctrlT   ctrl;
      wordT   aluOut;
      wordT   storeData;
      regIdxT rd;
   } exMemT;

   typedef struct packed {
      logic   valid;
      logic   regWrite;
      logic   halt;
      regIdxT rd;
      wordT   data;
   } memWbT;

   // Source registers read by the instruction in decode
   typedef struct packed {
      regIdxT rsIdx;
      logic   rsUsed;
      regIdxT rtIdx;
      logic   rtUsed;
   } srcUseT;

endpackage

/* logic/pipeReg.sv */
// Generic pipeline stage register with enable and flush, instantiated at each stage boundary
`timescale 1ns/1ps
`default_nettype none
module pipeReg #(
   parameter type T = logic
) (
   input  logic clk,
   input  logic rst,
   input  logic en,
   input  logic flush,
   input  T     d,
   output T     q
);

   // Flush wins over enable and leaves a bubble
   always_ff @(posedge clk) begin
      if (rst || flush) begin
         q <= '0;
      end else if (en) begin
         q <= d;
      end
   end

endmodule
`default_nettype wire

/* logic/fetch.sv */
// Fetch stage holding the PC and instruction memory, loaded through its write port during reset
`timescale 1ns/1ps
`default_nettype none
module fetch import procPkg::*; (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   stall,
   input  logic                   redirect,
   input  logic                   halted,
   input  wordT                   target,
   input  logic                   imemWe,
   input  logic [memAddrBits-1:0] imemAddr,
   input  wordT                   imemData,
   output ifIdT                   out
);

   wordT pc;
   wordT imem [imemDepth];

   // Program load port
   always_ff @(posedge clk) begin
      if (imemWe) begin
         imem[imemAddr] <= imemData;
      end
   end

   // Halt freezes everything, a redirect beats a stall
   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else if (halted) begin
         pc <= pc;
      end else if (redirect) begin
         pc <= target;
      end else if (!stall) begin
         pc <= pc + 16'd1;
      end
   end

   // Every fetched word is a real instruction; bubbles come from the stage registers
   always_comb begin
      out.valid = 1'b1;
      out.pc    = pc;
      out.instr = imem[pc[memAddrBits-1:0]];
   end

endmodule
`default_nettype wire

/* logic/regFile.sv */
// Eight-entry register file with two read ports, one write port and same-cycle write-through
`timescale 1ns/1ps
`default_nettype none
module regFile import procPkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  regIdxT rsIdx,
   input  regIdxT rtIdx,
   output wordT   rsData,
   output wordT   rtData,
   input  logic   we,
   input  regIdxT wrIdx,
   input  wordT   wrData
);

   wordT regs [8];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[wrIdx] <= wrData;
      end
   end

   // Write-back value is visible to decode in the same cycle
   assign rsData = (we && (wrIdx == rsIdx)) ? wrData : regs[rsIdx];
   assign rtData = (we && (wrIdx == rtIdx)) ? wrData : regs[rtIdx];

endmodule
`default_nettype wire

/* logic/decode.sv */
// Decode stage that builds control, extends immediates, reads registers and flags illegal opcodes
`timescale 1ns/1ps
`default_nettype none
module decode import procPkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  ifIdT   in,
   input  memWbT  wb,
   input  logic   flush,
   output idExT   out,
   output srcUseT src,
   output logic   err
);

   opcodeT op;
   ctrlT   ctrl;
   wordT   imm;
   regIdxT rd;
   logic   rsUsed;
   logic   rtUsed;
   logic   illegal;
   wordT   rsData;
   wordT   rtData;

   assign op = opcodeT'(in.instr[15:11]);

   regFile regs (
      .clk    (clk),
      .rst    (rst),
      .rsIdx  (in.instr[10:8]),
      .rtIdx  (in.instr[7:5]),
      .rsData (rsData),
      .rtData (rtData),
      .we     (wb.valid && wb.regWrite),
      .wrIdx  (wb.rd),
      .wrData (wb.data)
   );

   always_comb begin
      ctrl    = '0;
      imm     = {{11{in.instr[4]}}, in.instr[4:0]};
      rd      = in.instr[7:5];
      rsUsed  = 1'b0;
      rtUsed  = 1'b0;
      illegal = 1'b0;
      case (op)
         opHalt: ctrl.halt = 1'b1;
         opNop: ;
         opJ: begin
            ctrl.branch = brAlways;
            imm         = {{5{in.instr[10]}}, in.instr[10:0]};
         end
         opAddi, opSubi, opXori: begin
            // Low opcode bits line up with the ALU encoding
            ctrl.aluOp    = aluOpT'(in.instr[12:11]);
            ctrl.useImm   = 1'b1;
            ctrl.regWrite = 1'b1;
            rsUsed        = 1'b1;
         end
         opBeqz, opBnez: begin
            ctrl.branch = (op == opBeqz) ? brEqz : brNez;
            imm         = {{8{in.instr[7]}}, in.instr[7:0]};
            rsUsed      = 1'b1;
         end
         opSt: begin
            // Store data register rides on the rt port
            ctrl.useImm   = 1'b1;
            ctrl.memWrite = 1'b1;
            rsUsed        = 1'b1;
            rtUsed        = 1'b1;
         end
         opLd: begin
            ctrl.useImm   = 1'b1;
            ctrl.memRead  = 1'b1;
            ctrl.regWrite = 1'b1;
            rsUsed        = 1'b1;
         end
         opRtype: begin
            ctrl.aluOp    = aluOpT'(in.instr[1:0]);
            ctrl.regWrite = 1'b1;
            rd            = in.instr[4:2];
            rsUsed        = 1'b1;
            rtUsed        = 1'b1;
         end
         default: illegal = 1'b1;
      endcase
      // Bubbles carry no control and no sources
      if (!in.valid) begin
         ctrl    = '0;
         rsUsed  = 1'b0;
         rtUsed  = 1'b0;
         illegal = 1'b0;
      end
   end

   always_comb begin
      out.valid  = in.valid;
      out.ctrl   = ctrl;
      out.pc     = in.pc;
      out.rsData = rsData;
      out.rtData = rtData;
      out.imm    = imm;
      out.rd     = rd;
      src.rsIdx  = in.instr[10:8];
      src.rsUsed = rsUsed;
      src.rtIdx  = in.instr[7:5];
      src.rtUsed = rtUsed;
   end

   // Illegal word goes on as a NOP with control cleared
   assign err = illegal && !flush;

endmodule
`default_nettype wire

/* logic/stallUnit.sv */
// Hazard detection that holds decode while a source is still being produced further down
`timescale 1ns/1ps
`default_nettype none
module stallUnit import procPkg::*; (
   input  srcUseT src,
   input  idExT   exStage,
   input  exMemT  memStage,
   output logic   stall
);

   logic exWrites;
   logic memWrites;

   assign exWrites  = exStage.valid && exStage.ctrl.regWrite;
   assign memWrites = memStage.valid && memStage.ctrl.regWrite;

   function automatic logic pending(input regIdxT idx, input logic used);
      logic hitEx;
      logic hitMem;
      hitEx  = exWrites && (exStage.rd == idx);
      hitMem = memWrites && (memStage.rd == idx);
      return used && (hitEx || hitMem);
   endfunction

   // Write-back needs no check since the register file passes it through
   always_comb begin
      stall = pending(src.rsIdx, src.rsUsed) || pending(src.rtIdx, src.rtUsed);
   end

endmodule
`default_nettype wire

/* logic/execute.sv */
// Execute stage with the ALU, branch resolution and target computation for fetch redirect
`timescale 1ns/1ps
`default_nettype none
module execute import procPkg::*; (
   input  idExT  in,
   output exMemT out,
   output logic  redirect,
   output wordT  target
);

   wordT opB;
   wordT aluOut;
   logic taken;

   assign opB = in.ctrl.useImm ? in.imm : in.rtData;

   // Also forms the LD and ST address as rs plus imm
   always_comb begin
      case (in.ctrl.aluOp)
         aluAdd:  aluOut = in.rsData + opB;
         aluSub:  aluOut = in.rsData - opB;
         aluXor:  aluOut = in.rsData ^ opB;
         default: aluOut = in.rsData & opB;
      endcase
   end

   always_comb begin
      case (in.ctrl.branch)
         brEqz:    taken = (in.rsData == '0);
         brNez:    taken = (in.rsData != '0);
         brAlways: taken = 1'b1;
         default:  taken = 1'b0;
      endcase
   end

   // Relative to the next instruction
   assign target   = in.pc + 16'd1 + in.imm;
   assign redirect = in.valid && taken;

   always_comb begin
      out.valid     = in.valid;
      out.ctrl      = in.ctrl;
      out.aluOut    = aluOut;
      out.storeData = in.rtData;
      out.rd        = in.rd;
   end

endmodule
`default_nettype wire

/* logic/memory.sv */
// Memory stage with the data memory, write-back value selection and the sticky halt flag
`timescale 1ns/1ps
`default_nettype none
module memory import procPkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  exMemT in,
   output memWbT out,
   output logic  halted
);

   wordT                   dmem [dmemDepth];
   logic [memAddrBits-1:0] addr;
   logic                   storeNow;

   assign addr     = in.aluOut[memAddrBits-1:0];
   assign storeNow = in.valid && in.ctrl.memWrite && !halted;

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < dmemDepth; i++) begin
            dmem[i] <= '0;
         end
      end else if (storeNow) begin
         dmem[addr] <= in.storeData;
      end
   end

   // Set as HALT moves into write-back, cleared only by reset
   always_ff @(posedge clk) begin
      if (rst) begin
         halted <= 1'b0;
      end else if (in.valid && in.ctrl.halt) begin
         halted <= 1'b1;
      end
   end

   always_comb begin
      out.valid    = in.valid;
      out.regWrite = in.ctrl.regWrite;
      out.halt     = in.ctrl.halt;
      out.rd       = in.rd;
      out.data     = in.ctrl.memRead ? dmem[addr] : in.aluOut;
   end

endmodule
`default_nettype wire

/* logic/proc.sv */
// Processor top level wiring the five stages through their pipeline registers
`timescale 1ns/1ps
`default_nettype none
module proc import procPkg::*; (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   imemWe,
   input  logic [memAddrBits-1:0] imemAddr,
   input  wordT                   imemData,
   output logic                   halted,
   output logic                   err,
   output logic                   wbStrobe,
   output regIdxT                 wbReg,
   output wordT                   wbData
);

   ifIdT   ifIdD, ifIdQ;
   idExT   idExD, idExQ;
   exMemT  exMemD, exMemQ;
   memWbT  memWbD, memWbQ;
   srcUseT src;
   logic   stall;
   logic   redirect;
   wordT   target;

   fetch fetch0 (
      .clk      (clk),
      .rst      (rst),
      .stall    (stall),
      .redirect (redirect),
      .halted   (halted),
      .target   (target),
      .imemWe   (imemWe),
      .imemAddr (imemAddr),
      .imemData (imemData),
      .out      (ifIdD)
   );

   // Nothing moves or flushes once halted
   pipeReg #(.T(ifIdT)) ifIdReg (
      .clk(clk), .rst(rst), .en(!stall && !halted), .flush(redirect && !halted),
      .d(ifIdD), .q(ifIdQ)
   );

   decode decode0 (
      .clk   (clk),
      .rst   (rst),
      .in    (ifIdQ),
      .wb    (memWbQ),
      .flush (redirect),
      .out   (idExD),
      .src   (src),
      .err   (err)
   );

   stallUnit stall0 (.src(src), .exStage(idExQ), .memStage(exMemQ), .stall(stall));

   pipeReg #(.T(idExT)) idExReg (
      .clk(clk), .rst(rst), .en(!halted), .flush((redirect || stall) && !halted),
      .d(idExD), .q(idExQ)
   );

   execute execute0 (.in(idExQ), .out(exMemD), .redirect(redirect), .target(target));

   pipeReg #(.T(exMemT)) exMemReg (
      .clk(clk), .rst(rst), .en(!halted), .flush(1'b0), .d(exMemD), .q(exMemQ)
   );

   memory memory0 (.clk(clk), .rst(rst), .in(exMemQ), .out(memWbD), .halted(halted));

   pipeReg #(.T(memWbT)) memWbReg (
      .clk(clk), .rst(rst), .en(!halted), .flush(1'b0), .d(memWbD), .q(memWbQ)
   );

   // Write-back happens in decode's register file, observed here
   assign wbStrobe = memWbQ.valid && memWbQ.regWrite;
   assign wbReg    = memWbQ.rd;
   assign wbData   = memWbQ.data;

endmodule
`default_nettype wire

/* testbench/proc_properties.sv */
// Concurrent checks on reset, halt and redirect flushing, attached to every proc through bind
`timescale 1ns/1ps
module procProperties import procPkg::*; (
   input logic clk,
   input logic rst,
   input logic halted,
   input logic err,
   input logic wbStrobe,
   input logic redirect,
   input ifIdT ifIdQ,
   input idExT idExQ
);

   resetClears: assert property (@(posedge clk) rst |=> !halted && !err && !wbStrobe)
      else $error("halted, err or wbStrobe high in the cycle after reset");

   haltSticky: assert property (@(posedge clk) halted && !rst |=> halted)
      else $error("halted fell without reset");

   quietAfterHalt: assert property (@(posedge clk) halted |=> !wbStrobe)
      else $error("write-back strobe one cycle after halt");

   // A redirect leaves bubbles in IF/ID and ID/EX even while decode is stalled
   redirectFlushes: assert property (@(posedge clk) disable iff (rst)
      redirect && !halted |=> !ifIdQ.valid && !idExQ.valid)
      else $error("IF/ID or ID/EX still valid in the cycle after a redirect");

endmodule

bind proc procProperties props0 (
   .clk(clk), .rst(rst), .halted(halted), .err(err), .wbStrobe(wbStrobe),
   .redirect(redirect), .ifIdQ(ifIdQ), .idExQ(idExQ)
);

/* testbench/procTb.sv */
// Testbench for proc that runs random programs and checks each write-back against an ISA model
`timescale 1ns/1ps
module procTb import procPkg::*; ();

   // Undefined major opcodes used to plant illegal words
   localparam logic [4:0] badOps [4] = '{5'b00010, 5'b01111, 5'b10110, 5'b11111};

   logic                   clk = 1'b0;
   logic                   rst;
   logic                   imemWe;
   logic [memAddrBits-1:0] imemAddr;
   wordT                   imemData;
   logic                   halted;
   logic                   err;
   logic                   wbStrobe;
   regIdxT                 wbReg;
   wordT                   wbData;

   wordT   prog [imemDepth];
   regIdxT expReg [$];
   wordT   expVal [$];
   string  testName;
   logic   errSeen;
   int     len;
   int     cycles;
   int     cycleLimit;
   int     checked;
   regIdxT last1;
   regIdxT last2;

   always #10 clk = ~clk;

   proc dut0 (
      .clk(clk), .rst(rst), .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
      .halted(halted), .err(err), .wbStrobe(wbStrobe), .wbReg(wbReg), .wbData(wbData)
   );

   task automatic failRun(input string msg);
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic put(input wordT w);
      prog[len] = w;
      len++;
   endtask

   // Architectural execution of prog, producing the ordered register writes
   function automatic void runModel();
      wordT   regs [8];
      wordT   dm [dmemDepth];
      wordT   pc;
      wordT   ins;
      wordT   rs;
      wordT   rt;
      wordT   imm;
      wordT   val;
      regIdxT wi;
      logic   wr;
      logic   done;
      pc   = '0;
      done = 1'b0;
      for (int i = 0; i < 8; i++) regs[i] = '0;
      for (int i = 0; i < dmemDepth; i++) dm[i] = '0;
      expReg.delete();
      expVal.delete();
      while (!done) begin
         ins = prog[pc[memAddrBits-1:0]];
         pc  = pc + 16'd1;
         rs  = regs[ins[10:8]];
         rt  = regs[ins[7:5]];
         imm = {{11{ins[4]}}, ins[4:0]};
         wr  = ins[15:11] inside {opAddi, opSubi, opXori, opLd, opRtype};
         wi  = (ins[15:11] == opRtype) ? ins[4:2] : ins[7:5];
         val = '0;
         case (ins[15:11])
            opHalt:  done = 1'b1;
            opAddi:  val = rs + imm;
            opSubi:  val = rs - imm;
            opXori:  val = rs ^ imm;
            opLd:    val = dm[8'(rs + imm)];
            opSt:    dm[8'(rs + imm)] = rt;
            opBeqz:  if (rs == '0) pc = pc + {{8{ins[7]}}, ins[7:0]};
            opBnez:  if (rs != '0) pc = pc + {{8{ins[7]}}, ins[7:0]};
            opJ:     pc = pc + {{5{ins[10]}}, ins[10:0]};
            opRtype: begin
               case (ins[1:0])
                  2'd0:    val = rs + rt;
                  2'd1:    val = rs - rt;
                  2'd2:    val = rs ^ rt;
                  default: val = rs & rt;
               endcase
            end
            default: ;  // NOP and undefined opcodes
         endcase
         if (wr) begin
            regs[wi] = val;
            expReg.push_back(wi);
            expVal.push_back(val);
         end
      end
   endfunction

   task automatic seedRegs();
      for (int k = 1; k < 8; k++) put({opAddi, 3'd0, regIdxT'(k), 5'($urandom)});
      last1 = 3'd7;
      last2 = 3'd6;
   endtask

   // Chained ops read the two previous destinations, the others avoid them
   task automatic aluBlock(input int count, input logic chained);
      regIdxT rd;
      regIdxT rs;
      regIdxT rt;
      for (int n = 0; n < count; n++) begin
         rd = regIdxT'($urandom_range(1, 7));
         rs = last1;
         rt = last2;
         while (!chained && (rs == last1 || rs == last2)) rs = regIdxT'($urandom);
         while (!chained && (rt == last1 || rt == last2)) rt = regIdxT'($urandom);
         if ($urandom_range(0, 1) == 1) put({opRtype, rs, rt, rd, 2'($urandom)});
         else put({3'b010, 2'($urandom_range(0, 2)), rs, rd, 5'($urandom)});  // ADDI, SUBI, XORI
         last2 = last1;
         last1 = rd;
      end
   endtask

   task automatic memBlock();
      regIdxT      rd;
      logic [4:0]  addr;
      for (int n = 0; n < 16; n++) begin
         rd   = regIdxT'($urandom_range(1, 7));
         addr = 5'($urandom_range(0, 7));
         case ($urandom_range(0, 3))
            0: put({opSt, 3'd0, rd, addr});
            1: put({opLd, 3'd0, rd, addr});
            2: begin
               put({opSt, 3'd0, rd, addr});
               put({opLd, 3'd0, regIdxT'($urandom_range(1, 7)), addr});
            end
            default: put({opAddi, rd, rd, 5'($urandom)});
         endcase
      end
   endtask

   // Each branch skips the next two writes when taken
   task automatic branchBlock();
      regIdxT rd;
      for (int n = 0; n < 6; n++) begin
         rd = regIdxT'($urandom_range(1, 7));
         put({opAddi, 3'd0, rd, ($urandom_range(0, 1) == 1) ? 5'd0 : 5'($urandom_range(1, 15))});
         case ($urandom_range(0, 2))
            0: put({opBeqz, rd, 8'd2});
            1: put({opBnez, rd, 8'd2});
            default: put({opJ, 11'd2});
         endcase
         put({opAddi, regIdxT'($urandom), regIdxT'($urandom_range(1, 7)), 5'($urandom)});
         put({opXori, regIdxT'($urandom), regIdxT'($urandom_range(1, 7)), 5'($urandom)});
      end
   endtask

   task automatic runTest(input string name, input int kind);
      testName = name;
      len      = 0;
      // Spare words store to address 255, data register taken from the word address
      for (int i = 0; i < imemDepth; i++) begin
         prog[i] = {opSt, 3'd0, regIdxT'(i ^ (i >> 3) ^ (i >> 6)), 5'h1f};
      end
      case (kind)
         1: begin seedRegs(); aluBlock(12, 1'b0); end
         2: begin seedRegs(); aluBlock(16, 1'b1); end
         3: begin seedRegs(); memBlock(); end
         4: branchBlock();
         5: begin
            seedRegs();
            aluBlock(4, 1'b0);
            put({badOps[2'($urandom)], 11'($urandom)});
            aluBlock(4, 1'b0);
         end
         default: begin seedRegs(); aluBlock(5, 1'b0); end
      endcase
      put({opHalt, 11'd0});
      if (kind == 6) put({opAddi, 3'd0, 3'd1, 5'd5});
      runModel();
      cycleLimit += 6 * len + 40;
      // Program load while reset is held
      @(negedge clk);
      rst    = 1'b1;
      imemWe = 1'b1;
      for (int i = 0; i < imemDepth; i++) begin
         imemAddr = memAddrBits'(i);
         imemData = prog[i];
         @(negedge clk);
      end
      imemWe = 1'b0;
      repeat (5) @(negedge clk);
      errSeen = 1'b0;
      rst     = 1'b0;
      while (!halted) @(negedge clk);
      assert (expReg.size() == 0)
         else failRun($sformatf("%s: %0d expected writes missing at halt", name, expReg.size()));
      repeat (20) begin
         @(negedge clk);
         assert (halted && !wbStrobe) else failRun({name, ": pipeline moved after halt"});
      end
      assert (errSeen == (kind == 5)) else failRun({name, ": err did not match illegal words"});
   endtask

   always @(posedge clk) begin
      if (!rst) begin
         cycles++;
         assert (cycles <= cycleLimit) else failRun("Timeout: the run exceeded its cycle limit");
         if (err) errSeen = 1'b1;
         if (wbStrobe) begin
            assert (expReg.size() > 0) else failRun({testName, ": write-back with none expected"});
            assert (wbReg == expReg[0] && wbData == expVal[0])
               else failRun($sformatf("FAILED %s: expected r%0d = %h, actual r%0d = %h",
                  testName, expReg[0], expVal[0], wbReg, wbData));
            void'(expReg.pop_front());
            void'(expVal.pop_front());
            checked++;
         end
      end
   end

   initial begin
      void'($urandom(32'h4e28_b6b4));
      rst        = 1'b1;
      imemWe     = 1'b0;
      imemAddr   = '0;
      imemData   = '0;
      errSeen    = 1'b0;
      cycles     = 0;
      cycleLimit = 0;
      checked    = 0;
      runTest("aluIndependent", 1);
      runTest("aluChained", 2);
      runTest("loadStore", 3);
      runTest("branches", 4);
      runTest("illegalOpcode", 5);
      runTest("haltFreeze", 6);
      if (checked > 0) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else begin
         failRun("No register write was ever checked");
      end
   end

endmodule

/* proc.f */
logic/procPkg.sv
logic/pipeReg.sv
logic/fetch.sv
logic/regFile.sv
logic/decode.sv
logic/stallUnit.sv
logic/execute.sv
logic/memory.sv
logic/proc.sv
testbench/proc_properties.sv
testbench/procTb.sv

/* Makefile */
# Verilator build and run of the processor testbench
VERILATOR ?= verilator
TOP       ?= procTb
FILELIST  ?= proc.f
BUILDDIR  ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILDDIR)/V$(TOP)

$(BUILDDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: build
	./$(BUILDDIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR)
